/* bench/axi_mem_model.sv */
`timescale 1ns/1ps
`include "fabric_settings.svh"

module axi_mem_model import fabric_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  mem_arvalid,
  input  addr_t mem_araddr,
  input  logic  mem_rready,
  output logic  mem_arready,
  output logic  mem_rvalid,
  output data_t mem_rdata,
  output resp_t mem_rresp,
  input  logic  mem_awvalid,
  input  addr_t mem_awaddr,
  input  logic  mem_wvalid,
  input  data_t mem_wdata,
  input  strb_t mem_wstrb,
  input  logic  mem_bready,
  output logic  mem_awready,
  output logic  mem_wready,
  output logic  mem_bvalid,
  output resp_t mem_bresp,
  output int    clint_hits // reads of the clint window seen here
);

  data_t       mem [256]; // filled by the testbench at time zero
  logic [15:0] lfsr = 16'd38177;

  // galois lfsr stepped twice gives a delay of 0 to 3 cycles
  function automatic logic [1:0] pick_delay();
    logic [1:0] val;
    val = '0;
    for (int i = 0; i < 2; i++) begin
      val  = {val[0], lfsr[0]};
      lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
    end
    return val;
  endfunction

  initial begin : read_side
    addr_t      raddr;
    logic [1:0] delay;
    mem_arready = 1'b0;
    mem_rvalid  = 1'b0;
    mem_rdata   = '0;
    mem_rresp   = resp_okay;
    clint_hits  = 0;
    forever begin
      @(negedge clock);
      mem_arready = !reset;
      #5;
      if (!reset && mem_arvalid) begin
        if (mem_araddr >= `CLINT_BASE && mem_araddr < `CLINT_BASE + `CLINT_SIZE)
          clint_hits++;
        raddr = mem_araddr;
        delay = pick_delay();
        @(negedge clock);
        mem_arready = 1'b0;
        repeat (delay) @(negedge clock);
        mem_rvalid = 1'b1;
        mem_rdata  = mem[raddr[9:2]];
        #5;
        while (!mem_rready) begin
          @(negedge clock);
          #5;
        end
        @(negedge clock);
        mem_rvalid = 1'b0;
      end
    end
  end

  initial begin : write_side
    addr_t      waddr;
    data_t      wd;
    strb_t      ws;
    logic       got_aw, got_w, aw_now, w_now;
    logic [1:0] delay;
    mem_awready = 1'b0;
    mem_wready  = 1'b0;
    mem_bvalid  = 1'b0;
    mem_bresp   = resp_okay;
    forever begin
      @(negedge clock);
      if (!reset) begin
        mem_awready = 1'b1;
        mem_wready  = 1'b1;
        got_aw = 1'b0;
        got_w  = 1'b0;
        while (!(got_aw && got_w)) begin
          #5;
          aw_now = mem_awvalid && mem_awready;
          w_now  = mem_wvalid && mem_wready;
          if (aw_now) waddr = mem_awaddr;
          if (w_now) begin
            wd = mem_wdata;
            ws = mem_wstrb;
          end
          @(negedge clock);
          if (aw_now) begin
            got_aw = 1'b1;
            mem_awready = 1'b0;
          end
          if (w_now) begin
            got_w = 1'b1;
            mem_wready = 1'b0;
          end
        end
        for (int b = 0; b < 4; b++)
          if (ws[b]) mem[waddr[9:2]][8*b +: 8] = wd[8*b +: 8];
        delay = pick_delay();
        repeat (delay) @(negedge clock);
        mem_bvalid = 1'b1;
        #5;
        while (!mem_bready) begin
          @(negedge clock);
          #5;
        end
        @(negedge clock);
        mem_bvalid = 1'b0;
      end
    end
  end

endmodule

/* bench/mem_fabric_tb.sv */
`timescale 1ns/1ps
`include "fabric_settings.svh"

module mem_fabric_tb import fabric_pkg::*; ();

  localparam int    N_TXN    = 66; // reads and writes issued below
  localparam addr_t EXT_BASE = 32'h8000_0000;

  logic  clock, reset;
  logic  fetch_arvalid, fetch_rready, fetch_arready, fetch_rvalid;
  addr_t fetch_araddr;
  data_t fetch_rdata;
  resp_t fetch_rresp;
  logic  load_arvalid, load_rready, load_arready, load_rvalid;
  addr_t load_araddr;
  size_t load_arsize;
  data_t load_rdata;
  resp_t load_rresp;
  logic  store_awvalid, store_wvalid, store_bready;
  logic  store_awready, store_wready, store_bvalid;
  addr_t store_awaddr;
  size_t store_awsize;
  data_t store_wdata;
  strb_t store_wstrb;
  resp_t store_bresp;
  logic  mem_arvalid, mem_rready, mem_arready, mem_rvalid;
  addr_t mem_araddr;
  size_t mem_arsize;
  data_t mem_rdata;
  resp_t mem_rresp;
  logic  mem_awvalid, mem_wvalid, mem_bready, mem_awready, mem_wready, mem_bvalid;
  addr_t mem_awaddr;
  size_t mem_awsize;
  data_t mem_wdata;
  strb_t mem_wstrb;
  resp_t mem_bresp;
  int    clint_hits;

  data_t       shadow [256];
  addr_t       fetch_q[$]; // outstanding read addresses per requester
  addr_t       load_q[$];
  logic [15:0] lfsr = 16'd38177;
  int          errors = 0;
  int          checks = 0;
  logic        stalled [2];
  data_t       held_data [2];
  time         hs_time [2]; // last r handshake per requester (0 fetch, 1 load)

  mem_fabric i_mem_fabric (.*);
  axi_mem_model i_mem (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
    end
    return val;
  endfunction

  function automatic data_t fill_word(input addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t strb);
    data_t res;
    res = old;
    for (int b = 0; b < 4; b++)
      if (strb[b]) res[8*b +: 8] = wdata[8*b +: 8];
    return res;
  endfunction

  // expected response for a read
  // timer halves only get their resp compared
  function automatic void expected_read(input addr_t a, output data_t d, output resp_t r,
                                        output bit chk);
    addr_t off;
    off = a - `CLINT_BASE;
    chk = 1'b1;
    r   = resp_okay;
    d   = shadow[a[9:2]];
    if (a >= `CLINT_BASE && a < `CLINT_BASE + `CLINT_SIZE) begin
      d = '0;
      if (off == `CLINT_MTIME_LO_OFF || off == `CLINT_MTIME_HI_OFF) chk = 1'b0;
      else r = resp_slverr;
    end
  endfunction

  function automatic logic other_handshake(input int k);
    logic f, l, s;
    f = (fetch_arvalid && fetch_arready) || (fetch_rvalid && fetch_rready);
    l = (load_arvalid && load_arready) || (load_rvalid && load_rready);
    s = (store_awvalid && store_awready) || (store_bvalid && store_bready);
    return s || (k == 0 ? l : f);
  endfunction

  task automatic check_read(input int k);
    logic  v, r;
    data_t d, ed;
    resp_t rs, er;
    addr_t a;
    bit    chk;
    v  = k ? load_rvalid : fetch_rvalid;
    r  = k ? load_rready : fetch_rready;
    d  = k ? load_rdata : fetch_rdata;
    rs = k ? load_rresp : fetch_rresp;
    if (stalled[k]) begin
      checks++;
      assert (v && d == held_data[k]) else begin
        errors++;
        $display("Error at %0t: requester %0d response changed while stalled", $time, k);
      end
    end
    stalled[k]   = v && !r;
    held_data[k] = d;
    if (v && !r) begin
      checks++;
      assert (!other_handshake(k)) else begin
        errors++;
        $display("Error at %0t: handshake by another requester during stall", $time);
      end
    end
    if (v && r) begin
      hs_time[k] = $time;
      checks++;
      assert ((k ? load_q.size() : fetch_q.size()) != 0) else begin
        errors++;
        $display("requester %0d got a read response with no read outstanding", k);
      end
      if ((k ? load_q.size() : fetch_q.size()) != 0) begin
        if (k) a = load_q.pop_front();
        else a = fetch_q.pop_front();
        expected_read(a, ed, er, chk);
        checks++;
        assert (rs == er && (!chk || d == ed)) else begin
          errors++;
          $display("Error at %0t: read %h got %h/%0d, expected %h/%0d", $time, a, d, rs, ed, er);
        end
      end
    end
  endtask

  // compare process samples in the middle of the low phase
  initial begin
    stalled   = '{1'b0, 1'b0};
    held_data = '{'0, '0};
    hs_time   = '{0, 0};
    forever begin
      @(negedge clock);
      #5;
      if (!reset) begin
        check_read(0);
        check_read(1);
        if (store_bvalid && store_bready) begin
          checks++;
          assert (store_bresp == resp_okay) else begin
            errors++;
            $display("Error at %0t: store bresp %0d", $time, store_bresp);
          end
        end
        if (mem_arvalid && mem_arready) begin
          checks++;
          assert (mem_arsize == 3'd2) else begin
            errors++;
            $display("Error at %0t: memory read size %0d, expected word", $time, mem_arsize);
          end
        end
        if (mem_awvalid && mem_awready) begin
          checks++;
          assert (mem_awsize == 3'd2) else begin
            errors++;
            $display("Error at %0t: memory write size %0d, expected word", $time, mem_awsize);
          end
        end
      end
    end
  end

  task automatic do_read(input bit is_load, input addr_t a, input int stall, output data_t d);
    @(negedge clock);
    if (is_load) begin
      load_q.push_back(a);
      load_arvalid = 1'b1;
      load_araddr  = a;
      load_arsize  = 3'd2;
    end else begin
      fetch_q.push_back(a);
      fetch_arvalid = 1'b1;
      fetch_araddr  = a;
    end
    #5;
    while (!(is_load ? load_arready : fetch_arready)) begin
      @(negedge clock);
      #5;
    end
    @(negedge clock);
    if (is_load) load_arvalid = 1'b0;
    else fetch_arvalid = 1'b0;
    repeat (stall) @(negedge clock); // rready low for a while
    if (is_load) load_rready = 1'b1;
    else fetch_rready = 1'b1;
    #5;
    while (!(is_load ? load_rvalid : fetch_rvalid)) begin
      @(negedge clock);
      #5;
    end
    d = is_load ? load_rdata : fetch_rdata;
    @(negedge clock);
    if (is_load) load_rready = 1'b0;
    else fetch_rready = 1'b0;
  endtask

  task automatic do_store(input addr_t a, input data_t wd, input strb_t ws);
    logic aw_hs, w_hs;
    shadow[a[9:2]] = merge_bytes(shadow[a[9:2]], wd, ws);
    @(negedge clock);
    store_awvalid = 1'b1;
    store_wvalid  = 1'b1;
    store_awaddr  = a;
    store_awsize  = 3'd2;
    store_wdata   = wd;
    store_wstrb   = ws;
    while (store_awvalid || store_wvalid) begin
      #5;
      aw_hs = store_awvalid && store_awready;
      w_hs  = store_wvalid && store_wready;
      @(negedge clock);
      if (aw_hs) store_awvalid = 1'b0;
      if (w_hs) store_wvalid = 1'b0;
    end
    store_bready = 1'b1;
    #5;
    while (!store_bvalid) begin
      @(negedge clock);
      #5;
    end
    @(negedge clock);
    store_bready = 1'b0;
  endtask

  function automatic addr_t rand_ext_addr();
    return EXT_BASE + (rand_bits(8) << 2);
  endfunction

  initial begin
    addr_t a, a2;
    data_t rd0, rd1, hi, lo, prev_hi, prev_lo;
    int    s0, s1;
    reset = 1'b1;
    {fetch_arvalid, fetch_rready, load_arvalid, load_rready} = '0;
    {store_awvalid, store_wvalid, store_bready} = '0;
    fetch_araddr = '0;
    load_araddr  = '0;
    load_arsize  = '0;
    store_awaddr = '0;
    store_awsize = '0;
    store_wdata  = '0;
    store_wstrb  = '0;
    for (int i = 0; i < 256; i++) begin
      shadow[i]     = fill_word(EXT_BASE + addr_t'(i * 4));
      i_mem.mem[i]  = shadow[i];
    end
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    repeat (16) do_read(1'b0, rand_ext_addr(), int'(rand_bits(3)), rd0);

    repeat (16) begin
      a = rand_ext_addr();
      do_store(a, rand_bits(32), strb_t'(rand_bits(4)));
      do_read(1'b1, a, int'(rand_bits(3)), rd1);
    end

    // fetch and load raised in the same idle cycle so the load wins
    repeat (4) begin
      a  = rand_ext_addr();
      a2 = rand_ext_addr();
      s0 = int'(rand_bits(3));
      s1 = int'(rand_bits(3));
      fork
        do_read(1'b0, a, s0, rd0);
        do_read(1'b1, a2, s1, rd1);
      join
      checks++;
      assert (hs_time[1] < hs_time[0]) else begin
        errors++;
        $display("Error at %0t: fetch finished before the load", $time);
      end
    end

    prev_hi = '0;
    prev_lo = '0;
    for (int i = 0; i < 4; i++) begin
      do_read(1'b1, `CLINT_BASE + `CLINT_MTIME_HI_OFF, int'(rand_bits(3)), hi);
      do_read(1'b1, `CLINT_BASE + `CLINT_MTIME_LO_OFF, int'(rand_bits(3)), lo);
      checks++;
      assert (hi == '0) else begin // run is far shorter than 2**32 cycles
        errors++;
        $display("Error at %0t: mtime high word %h, expected zero", $time, hi);
      end
      if (i > 0 && hi == prev_hi) begin
        checks++;
        assert (lo >= prev_lo) else begin
          errors++;
          $display("Error at %0t: mtime low went from %h to %h", $time, prev_lo, lo);
        end
      end
      prev_hi = hi;
      prev_lo = lo;
    end
    do_read(1'b0, `CLINT_BASE + 32'h8, 0, rd0);
    do_read(1'b1, `CLINT_BASE + 32'h4000, 2, rd1);

    repeat (3) @(negedge clock);
    checks++;
    assert (clint_hits == 0) else begin
      errors++;
      $display("Error at %0t: %0d CLINT reads reached memory", $time, clint_hits);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog allows 40 cycles per transaction plus reset
  initial begin
    repeat (N_TXN * 40 + 10) @(posedge clock);
    $display("timeout, the transactions did not all complete in time");
    $display("checks %0d, errors %0d", checks, errors);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* hw/axi_read_if.sv */
`timescale 1ns/1ps

interface axi_read_if import fabric_pkg::*; ();

  // address channel
  logic  arvalid;
  logic  arready;
  addr_t araddr;
  size_t arsize;

  // data channel
  logic  rvalid;
  logic  rready;
  data_t rdata;
  resp_t rresp;

  modport initiator (
    output arvalid,
    output araddr,
    output arsize,
    output rready,
    input  arready,
    input  rvalid,
    input  rdata,
    input  rresp
  );

  modport target (
    input  arvalid,
    input  araddr,
    input  arsize,
    input  rready,
    output arready,
    output rvalid,
    output rdata,
    output rresp
  );

endinterface

/* hw/axi_write_if.sv */
`timescale 1ns/1ps

interface axi_write_if import fabric_pkg::*; ();

  logic  awvalid; // address channel
  logic  awready;
  addr_t awaddr;
  size_t awsize;

  logic  wvalid; // data channel
  logic  wready;
  data_t wdata;
  strb_t wstrb;

  logic  bvalid; // response channel
  logic  bready;
  resp_t bresp;

  modport initiator (
    output awvalid, awaddr, awsize,
    output wvalid, wdata, wstrb,
    output bready,
    input  awready,
    input  wready,
    input  bvalid, bresp
  );

  modport target (
    input  awvalid, awaddr, awsize,
    input  wvalid, wdata, wstrb,
    input  bready,
    output awready,
    output wready,
    output bvalid, bresp
  );

endinterface

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter import fabric_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  fetch_arvalid,
  input  addr_t fetch_araddr,
  input  logic  fetch_rready,
  output logic  fetch_arready,
  output logic  fetch_rvalid,
  output data_t fetch_rdata,
  output resp_t fetch_rresp,
  input  logic  load_arvalid,
  input  addr_t load_araddr,
  input  size_t load_arsize,
  input  logic  load_rready,
  output logic  load_arready,
  output logic  load_rvalid,
  output data_t load_rdata,
  output resp_t load_rresp,
  input  logic  store_awvalid,
  input  addr_t store_awaddr,
  input  size_t store_awsize,
  input  logic  store_wvalid,
  input  data_t store_wdata,
  input  strb_t store_wstrb,
  input  logic  store_bready,
  output logic  store_awready,
  output logic  store_wready,
  output logic  store_bvalid,
  output resp_t store_bresp,
  axi_read_if.initiator  rd,
  axi_write_if.initiator wr
);

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_load,
    st_store
  } state_t;

  state_t state;
  logic   ar_done; // address phase finished for this grant
  logic   aw_done;
  logic   w_done;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= st_idle;
      ar_done <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          ar_done <= 1'b0;
          aw_done <= 1'b0;
          w_done  <= 1'b0;
          // load first, then store, fetch last
          if (load_arvalid) state <= st_load;
          else if (store_awvalid && store_wvalid) state <= st_store;
          else if (fetch_arvalid) state <= st_fetch;
        end
        st_fetch, st_load: begin
          if (rd.arvalid && rd.arready) ar_done <= 1'b1;
          if (rd.rvalid && rd.rready) state <= st_idle; // r handshake ends the grant
        end
        st_store: begin
          if (wr.awvalid && wr.awready) aw_done <= 1'b1;
          if (wr.wvalid && wr.wready) w_done <= 1'b1;
          if (wr.bvalid && wr.bready) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // granted read goes out to the router
  assign rd.arvalid = !ar_done && ((state == st_fetch && fetch_arvalid) ||
                                   (state == st_load && load_arvalid));
  assign rd.araddr  = (state == st_load) ? load_araddr : fetch_araddr;
  assign rd.arsize  = (state == st_load) ? load_arsize : 3'd2; // fetch is always a word
  assign rd.rready  = (state == st_fetch && fetch_rready) || (state == st_load && load_rready);

  assign fetch_arready = (state == st_fetch) && !ar_done && rd.arready;
  assign fetch_rvalid  = (state == st_fetch) && rd.rvalid;
  assign fetch_rdata   = rd.rdata;
  assign fetch_rresp   = rd.rresp;

  assign load_arready = (state == st_load) && !ar_done && rd.arready;
  assign load_rvalid  = (state == st_load) && rd.rvalid;
  assign load_rdata   = rd.rdata;
  assign load_rresp   = rd.rresp;

  // store channels, aw and w may finish on different edges
  assign wr.awvalid = (state == st_store) && store_awvalid && !aw_done;
  assign wr.awaddr  = store_awaddr;
  assign wr.awsize  = store_awsize;
  assign wr.wvalid  = (state == st_store) && store_wvalid && !w_done;
  assign wr.wdata   = store_wdata;
  assign wr.wstrb   = store_wstrb;
  assign wr.bready  = (state == st_store) && store_bready;

  assign store_awready = (state == st_store) && !aw_done && wr.awready;
  assign store_wready  = (state == st_store) && !w_done && wr.wready;
  assign store_bvalid  = (state == st_store) && wr.bvalid;
  assign store_bresp   = wr.bresp;

endmodule

/* hw/clint_timer.sv */
`timescale 1ns/1ps
`include "fabric_settings.svh"

module clint_timer import fabric_pkg::*; (
  input  logic clock,
  input  logic reset,
  axi_read_if.target bus
);

  logic [63:0] mtime;
  logic        rvalid_q;
  data_t       rdata_q;
  resp_t       rresp_q;
  addr_t       offset; // position inside the clint window

  assign offset = bus.araddr - addr_t'(`CLINT_BASE);

  // free running machine timer
  always_ff @(posedge clock) begin
    if (reset) mtime <= 64'd0;
    else mtime <= mtime + 64'd1;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid_q <= 1'b0;
    end else if (bus.arvalid && bus.arready) begin
      rvalid_q <= 1'b1; // answer on the next cycle
    end else if (bus.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // capture the selected half at the ar handshake
  always_ff @(posedge clock) begin
    if (bus.arvalid && bus.arready) begin
      case (offset)
        `CLINT_MTIME_LO_OFF: begin
          rdata_q <= mtime[31:0];
          rresp_q <= resp_okay;
        end
        `CLINT_MTIME_HI_OFF: begin
          rdata_q <= mtime[63:32];
          rresp_q <= resp_okay;
        end
        default: begin
          rdata_q <= '0;
          rresp_q <= resp_slverr; // unmapped clint offset
        end
      endcase
    end
  end

  assign bus.arready = !rvalid_q;
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = rresp_q;

endmodule

/* hw/fabric_pkg.sv */
`include "fabric_settings.svh"

package fabric_pkg;

  // byte address
  typedef logic [`FABRIC_ADDR_W-1:0] addr_t;

  // one data beat
  typedef logic [`FABRIC_DATA_W-1:0] data_t;

  typedef logic [`FABRIC_DATA_W/8-1:0] strb_t; // one bit per byte lane

  // axsize encoding, 0 byte, 1 half, 2 word
  typedef logic [2:0] size_t;

  // AXI response codes
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01, // never produced here
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_t;

endpackage

/* hw/fabric_settings.svh */
`ifndef FABRIC_SETTINGS_SVH
`define FABRIC_SETTINGS_SVH

// bus widths
`define FABRIC_ADDR_W 32
`define FABRIC_DATA_W 32

// clint window, reads only
`define CLINT_BASE 32'h0200_0000
`define CLINT_SIZE 32'h0001_0000

// timer words inside the window
`define CLINT_MTIME_LO_OFF 32'h0000_0000 // mtime[31:0]
`define CLINT_MTIME_HI_OFF 32'h0000_0004 // mtime[63:32]

`endif

/* hw/mem_fabric.sv */
`timescale 1ns/1ps

module mem_fabric import fabric_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  // instruction fetch
  input  logic  fetch_arvalid,
  input  addr_t fetch_araddr,
  input  logic  fetch_rready,
  output logic  fetch_arready,
  output logic  fetch_rvalid,
  output data_t fetch_rdata,
  output resp_t fetch_rresp,
  // data load
  input  logic  load_arvalid,
  input  addr_t load_araddr,
  input  size_t load_arsize,
  input  logic  load_rready,
  output logic  load_arready,
  output logic  load_rvalid,
  output data_t load_rdata,
  output resp_t load_rresp,
  // data store
  input  logic  store_awvalid,
  input  addr_t store_awaddr,
  input  size_t store_awsize,
  input  logic  store_wvalid,
  input  data_t store_wdata,
  input  strb_t store_wstrb,
  input  logic  store_bready,
  output logic  store_awready,
  output logic  store_wready,
  output logic  store_bvalid,
  output resp_t store_bresp,
  // external memory, read side
  output logic  mem_arvalid,
  output addr_t mem_araddr,
  output size_t mem_arsize,
  output logic  mem_rready,
  input  logic  mem_arready,
  input  logic  mem_rvalid,
  input  data_t mem_rdata,
  input  resp_t mem_rresp,
  // external memory, write side
  output logic  mem_awvalid,
  output addr_t mem_awaddr,
  output size_t mem_awsize,
  output logic  mem_wvalid,
  output data_t mem_wdata,
  output strb_t mem_wstrb,
  output logic  mem_bready,
  input  logic  mem_awready,
  input  logic  mem_wready,
  input  logic  mem_bvalid,
  input  resp_t mem_bresp
);

  axi_read_if  arb_rd ();   // arbiter to router
  axi_read_if  clint_rd (); // router to timer
  axi_write_if arb_wr ();   // granted store

  bus_arbiter i_bus_arbiter (
    .rd (arb_rd.initiator),
    .wr (arb_wr.initiator),
    .*
  );

  read_router i_read_router (
    .up    (arb_rd.target),
    .clint (clint_rd.initiator),
    .*
  );

  clint_timer i_clint_timer (
    .clock (clock),
    .reset (reset),
    .bus   (clint_rd.target)
  );

  // write side goes straight to the external port
  assign mem_awvalid = arb_wr.awvalid;
  assign mem_awaddr  = arb_wr.awaddr;
  assign mem_awsize  = arb_wr.awsize;
  assign mem_wvalid  = arb_wr.wvalid;
  assign mem_wdata   = arb_wr.wdata;
  assign mem_wstrb   = arb_wr.wstrb;
  assign mem_bready  = arb_wr.bready;

  assign arb_wr.awready = mem_awready;
  assign arb_wr.wready  = mem_wready;
  assign arb_wr.bvalid  = mem_bvalid;
  assign arb_wr.bresp   = mem_bresp;

endmodule

/* hw/read_router.sv */
`timescale 1ns/1ps
`include "fabric_settings.svh"

module read_router import fabric_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  axi_read_if.target    up,
  axi_read_if.initiator clint,
  output logic  mem_arvalid,
  output addr_t mem_araddr,
  output size_t mem_arsize,
  output logic  mem_rready,
  input  logic  mem_arready,
  input  logic  mem_rvalid,
  input  data_t mem_rdata,
  input  resp_t mem_rresp
);

  logic hit_clint; // address decode for the current request
  logic pending;   // ar accepted, r not yet
  logic sel_clint; // target of the pending read

  assign hit_clint = (up.araddr >= addr_t'(`CLINT_BASE)) &&
                     (up.araddr < addr_t'(`CLINT_BASE + `CLINT_SIZE));

  always_ff @(posedge clock) begin
    if (reset) begin
      pending   <= 1'b0;
      sel_clint <= 1'b0;
    end else if (up.arvalid && up.arready) begin
      pending   <= 1'b1;
      sel_clint <= hit_clint; // keep the decision for the response
    end else if (up.rvalid && up.rready) begin
      pending <= 1'b0;
    end
  end

  // address channel, only the selected side sees arvalid
  assign clint.arvalid = up.arvalid && hit_clint;
  assign clint.araddr  = up.araddr;
  assign clint.arsize  = up.arsize;

  assign mem_arvalid = up.arvalid && !hit_clint;
  assign mem_araddr  = up.araddr;
  assign mem_arsize  = up.arsize;

  assign up.arready = hit_clint ? clint.arready : mem_arready;

  // response path follows the latched selection
  assign up.rvalid = pending && (sel_clint ? clint.rvalid : mem_rvalid);
  assign up.rdata  = sel_clint ? clint.rdata : mem_rdata;
  assign up.rresp  = sel_clint ? clint.rresp : mem_rresp;

  assign clint.rready = pending && sel_clint && up.rready;
  assign mem_rready   = pending && !sel_clint && up.rready;

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the fabric testbench with verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module mem_fabric_tb -f src.f -o sim_fabric \
  && ./obj_dir/sim_fabric > sim.log 2>&1 \
  || echo "build or simulation stopped with an error"

cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

/* src.f */
+incdir+hw
hw/fabric_pkg.sv
hw/axi_read_if.sv
hw/axi_write_if.sv
hw/bus_arbiter.sv
hw/read_router.sv
hw/clint_timer.sv
hw/mem_fabric.sv
bench/axi_mem_model.sv
bench/mem_fabric_tb.sv
